/* src/echo_defs.svh */
`ifndef ECHO_DEFS_SVH
`define ECHO_DEFS_SVH

// Program counter values
`define RESET_PC       32'd44
`define HANDLER_PC     32'd0

// Peripheral data registers
`define KBD_DATA_ADDR  64'h0000_0000_8000_1000
`define ART_DATA_ADDR  64'h0000_0000_8000_0000

// Queue depths
`define KBD_DEPTH      4
`define ART_DEPTH      8

`endif

/* src/echo_pkg.sv */
`default_nettype none

package echo_pkg;

    // One request on the shared peripheral bus
    typedef struct packed {
        logic        read;   // Read strobe
        logic        write;  // Write strobe
        logic [63:0] addr;   // Byte address
        logic [63:0] wdata;  // Write payload
    } bus_req_t;

    // Register-file write trace
    typedef struct packed {
        logic        valid;  // One cycle per retired write
        logic [4:0]  rd;     // Destination register
        logic [63:0] data;   // Value written
    } rf_write_t;

    // Keyboard event, release flag on top so it lands at bit 8 of read data
    typedef struct packed {
        logic       released;  // Key release, not press
        logic [7:0] code;      // Scan code
    } key_t;

    // Output character
    typedef struct packed {
        logic [7:0] code;
    } char_t;

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [0:DEPTH-1];  // Storage, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;             // Occupancy
    logic             do_push;
    logic             do_pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign do_push = push && !full;  // Push into full queue is lost
    assign do_pop  = pop && !empty;  // Pop of empty queue ignored
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign head    = mem[rd_ptr];    // Oldest entry, straight from storage

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/echo_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "echo_defs.svh"

module echo_core import echo_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction,
    output logic [31:0] pc,
    input  logic        irq,
    output logic        irq_ack,
    output bus_req_t    bus_req,
    input  logic [63:0] bus_rdata,
    output rf_write_t   rf_write
);
    logic [31:0] ir;             // Word fetched at pc - 4
    logic [63:0] regs [0:31];    // Register file, read back by the trace
    logic [31:0] mepc;           // Saved return PC
    logic        in_handler;     // Inside interrupt handler
    logic        bubble;         // Discard ir this cycle
    logic        echo_step;      // ECHO second step
    logic        bus_rd;
    logic        bus_wr;
    logic [63:0] bus_addr;
    logic [63:0] bus_wdata;
    logic        rf_valid;
    logic [4:0]  rf_rd;

    logic [63:0] imm_u;
    logic [4:0]  rd;
    logic        exec_ok;
    logic        is_lui;
    logic        is_mret;
    logic        is_echo;
    logic        echo_start;
    logic        take_irq;
    logic        lui_wr;

    // Decode
    assign imm_u   = {{32{ir[31]}}, ir[31:12], 12'b0};  // Sign-extended U-type immediate
    assign rd      = ir[11:7];
    assign exec_ok = !bubble && !echo_step;  // ir holds a live word
    assign is_lui  = (ir[6:0] == 7'b0110111);
    assign is_mret = (ir == 32'h0000_0000);
    assign is_echo = (ir == 32'hffff_ffff);

    assign echo_start = exec_ok && is_echo;
    // No entry in the middle of an ECHO transfer
    assign take_irq   = irq && !in_handler && !echo_step && !echo_start;
    assign lui_wr     = exec_ok && is_lui && (rd != 5'd0);  // x0 stays zero

    assign bus_req  = '{read: bus_rd, write: bus_wr, addr: bus_addr, wdata: bus_wdata};
    assign rf_write = '{valid: rf_valid, rd: rf_rd, data: regs[rf_rd]};

    // Fetch every cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= 32'h0000_0001;  // No-op
        end else begin
            ir <= instruction;
        end
    end

    // PC, handler state and bus strobes
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc         <= `RESET_PC;
            bubble     <= 1'b0;
            echo_step  <= 1'b0;
            in_handler <= 1'b0;
            irq_ack    <= 1'b0;
            bus_rd     <= 1'b0;
            bus_wr     <= 1'b0;
            rf_valid   <= 1'b0;
        end else begin
            pc       <= pc + 32'd4;
            bubble   <= 1'b0;
            irq_ack  <= 1'b0;
            bus_rd   <= 1'b0;
            bus_wr   <= 1'b0;
            rf_valid <= lui_wr;
            if (take_irq) begin
                pc         <= `HANDLER_PC;  // LUI in ir still retires
                bubble     <= 1'b1;
                irq_ack    <= 1'b1;
                in_handler <= 1'b1;
            end else if (echo_step) begin
                echo_step <= 1'b0;  // Refetched word in ir acts as bubble
                bus_wr    <= 1'b1;
            end else if (echo_start) begin
                pc        <= pc;     // Hold for the refetch
                echo_step <= 1'b1;
                bus_rd    <= 1'b1;
            end else if (exec_ok && is_mret) begin
                pc         <= mepc;
                bubble     <= 1'b1;
                in_handler <= 1'b0;
            end
        end
    end

    // Payload side
    always_ff @(posedge clk) begin
        if (take_irq) begin
            mepc <= pc;  // Next word not yet executed
        end
        if (echo_start) begin
            bus_addr <= `KBD_DATA_ADDR;
        end else if (echo_step) begin
            bus_addr  <= `ART_DATA_ADDR;
            bus_wdata <= bus_rdata;  // Key from the read cycle
        end
        if (lui_wr) begin
            regs[rd] <= imm_u;
            rf_rd    <= rd;
        end
    end

endmodule

`default_nettype wire

/* src/kbd_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "echo_defs.svh"

module kbd_port import echo_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        key_valid,
    input  key_t        key,
    input  bus_req_t    bus_req,
    output logic [63:0] bus_rdata,
    output logic        irq,
    output logic        kbd_overflow
);
    logic rd_hit;
    key_t head;
    logic empty;
    logic full;

    assign rd_hit = bus_req.read && (bus_req.addr == `KBD_DATA_ADDR);

    // Pop lands on the edge that closes the read cycle
    sync_fifo #(
        .payload_t (key_t),
        .DEPTH     (`KBD_DEPTH)
    ) u_key_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (key_valid),
        .push_data (key),
        .pop       (rd_hit),
        .head      (head),
        .empty     (empty),
        .full      (full)
    );

    // Zero when not addressed or nothing queued
    assign bus_rdata = (rd_hit && !empty) ? {55'd0, head} : 64'd0;
    assign irq       = !empty;  // Level while keys wait

    // Sticky, cleared only by reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            kbd_overflow <= 1'b0;
        end else if (key_valid && full) begin
            kbd_overflow <= 1'b1;  // Key dropped
        end
    end

endmodule

`default_nettype wire

/* src/art_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "echo_defs.svh"

module art_port import echo_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    input  logic     art_ready,
    output logic     char_valid,
    output char_t    char_out
);
    logic  wr_hit;
    char_t wr_char;
    logic  empty;
    logic  pop;

    assign wr_hit  = bus_req.write && (bus_req.addr == `ART_DATA_ADDR);
    assign wr_char = char_t'(bus_req.wdata[7:0]);  // Low byte only
    // Sink takes one character per ready cycle
    assign pop     = art_ready && !empty;

    // Writes into a full queue vanish inside the FIFO
    sync_fifo #(
        .payload_t (char_t),
        .DEPTH     (`ART_DEPTH)
    ) u_char_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (wr_hit),
        .push_data (wr_char),
        .pop       (pop),
        .head      (char_out),  // Registered queue head
        .empty     (empty),
        .full      ()
    );

    assign char_valid = pop;  // Same cycle as the pop

endmodule

`default_nettype wire

/* src/echo_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module echo_soc import echo_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction,
    output logic [31:0] pc,
    input  logic        key_valid,
    input  key_t        key,
    input  logic        art_ready,
    output logic        char_valid,
    output char_t       char_out,
    output logic        irq_ack,
    output rf_write_t   rf_write,
    output logic        kbd_overflow
);
    bus_req_t    bus_req;    // Core is sole master
    logic [63:0] bus_rdata;  // Only the keyboard answers reads
    logic        irq;

    echo_core u_echo_core (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .irq         (irq),
        .irq_ack     (irq_ack),
        .bus_req     (bus_req),
        .bus_rdata   (bus_rdata),
        .rf_write    (rf_write)
    );

    kbd_port u_kbd_port (
        .clk          (clk),
        .reset        (reset),
        .key_valid    (key_valid),
        .key          (key),
        .bus_req      (bus_req),
        .bus_rdata    (bus_rdata),
        .irq          (irq),
        .kbd_overflow (kbd_overflow)
    );

    art_port u_art_port (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .art_ready  (art_ready),
        .char_valid (char_valid),
        .char_out   (char_out)
    );

endmodule

`default_nettype wire

/* dv/echo_soc_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module echo_soc_properties import echo_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     irq_ack,
    input logic     char_valid,
    input logic     art_ready,
    input bus_req_t bus_req
);
    int assert_fails = 0;  // Read by the testbench at the end

    // Entry acknowledge is a single pulse
    ack_single: assert property (@(posedge clk) disable iff (!reset) irq_ack |=> !irq_ack)
        else begin
            assert_fails++;
            $error("irq_ack high for two cycles");
        end

    // Sink only takes data when ready
    char_needs_ready: assert property (@(posedge clk) disable iff (!reset)
        char_valid |-> art_ready)
        else begin
            assert_fails++;
            $error("char_valid without art_ready");
        end

    bus_one_strobe: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req.read && bus_req.write))
        else begin
            assert_fails++;
            $error("Bus read and write strobes together");
        end

endmodule

bind echo_soc echo_soc_properties u_echo_soc_properties (
    .clk        (clk),
    .reset      (reset),
    .irq_ack    (irq_ack),
    .char_valid (char_valid),
    .art_ready  (art_ready),
    .bus_req    (bus_req)
);

`default_nettype wire

/* dv/echo_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "echo_defs.svh"

module echo_soc_tb import echo_pkg::*; ();
    localparam logic [31:0] NOP_WORD  = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] MRET_WORD = 32'h0000_0000;
    localparam logic [31:0] ECHO_WORD = 32'hffff_ffff;
    localparam int          WAIT_MAX  = 200;            // Cycles per wait loop

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        key_valid;
    key_t        key;
    logic        art_ready;
    logic        char_valid;
    char_t       char_out;
    logic        irq_ack;
    rf_write_t   rf_write;
    logic        kbd_overflow;

    logic [31:0] prog [int unsigned];  // Program model keyed by byte address
    char_t       seen_chars [$];       // Characters taken by the sink
    int unsigned lcg_state;
    int          errors;
    int          timeouts;

    echo_soc u_echo_soc (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .pc           (pc),
        .key_valid    (key_valid),
        .key          (key),
        .art_ready    (art_ready),
        .char_valid   (char_valid),
        .char_out     (char_out),
        .irq_ack      (irq_ack),
        .rf_write     (rf_write),
        .kbd_overflow (kbd_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory answers whatever pc points at
    always @(pc) begin
        instruction <= fetch_word(pc);
    end

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (prog.exists(addr)) begin
            return prog[addr];
        end
        return NOP_WORD;  // Unloaded address
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [7:0] random_code();
        logic [31:0] rnd;
        rnd = lcg_next();
        return rnd[23:16];  // Upper bits spread better
    endfunction

    task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_char(input string name, input char_t exp, input char_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_rf_write(input string name, input rf_write_t exp, input rf_write_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected v=%b rd=%0d %h, got v=%b rd=%0d %h",
                     $time, name, exp.valid, exp.rd, exp.data,
                     act.valid, act.rd, act.data);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic sample_chars();
        if (char_valid) begin
            seen_chars.push_back(char_out);
        end
    endtask

    // One strobe per key on consecutive cycles
    task automatic press_keys(input logic [7:0] codes [$]);
        foreach (codes[i]) begin
            @(posedge clk);
            key_valid <= 1'b1;
            key       <= '{released: 1'b0, code: codes[i]};
        end
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    // Follows one interrupt from entry to MRET
    task automatic await_return();
        logic [31:0] prev_pc;
        logic [31:0] saved;
        int          acks;
        int          cycles;
        bit          returned;
        acks     = 0;
        cycles   = 0;
        returned = 1'b0;
        saved    = '0;
        @(negedge clk);
        sample_chars();
        prev_pc = pc;
        while (!returned && cycles < WAIT_MAX) begin
            @(negedge clk);
            sample_chars();
            cycles++;
            if (irq_ack) begin
                acks++;
                saved = prev_pc;  // Pc of the entry cycle
                check_pc("pc", `HANDLER_PC, pc);
            end else if (acks > 0 && pc != prev_pc + 32'd4 && pc != prev_pc) begin
                returned = 1'b1;  // Redirect out of the handler
                check_pc("pc", saved, pc);
            end
            prev_pc = pc;
        end
        if (!returned) begin
            report_timeout("the return from the interrupt handler");
        end else if (acks != 1) begin
            errors++;
            $display("Saw %0d irq_ack pulses for one interrupt instead of one", acks);
        end
    endtask

    task automatic collect_chars(input logic [7:0] codes [$]);
        int cycles;
        cycles = 0;
        while (seen_chars.size() < codes.size() && cycles < WAIT_MAX) begin
            @(negedge clk);
            sample_chars();
            cycles++;
        end
        if (seen_chars.size() < codes.size()) begin
            report_timeout("echoed characters");
        end
        repeat (8) begin
            @(negedge clk);
            sample_chars();  // Catch late extras
        end
        if (seen_chars.size() > codes.size()) begin
            errors++;
            $display("Sink got %0d characters, expected %0d", seen_chars.size(), codes.size());
        end
        foreach (codes[i]) begin
            if (i < seen_chars.size()) begin
                check_char("char_out", char_t'(codes[i]), seen_chars[i]);
            end
        end
        seen_chars.delete();
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_pc("pc", `RESET_PC, pc);
        check_flag("irq_ack", 1'b0, irq_ack);
        check_flag("char_valid", 1'b0, char_valid);
        check_flag("rf_write.valid", 1'b0, rf_write.valid);
        check_flag("kbd_overflow", 1'b0, kbd_overflow);
    endtask

    task automatic lui_trace();
        rf_write_t   expected [$];
        rf_write_t   entry;
        logic [31:0] imm;
        logic [31:0] base;
        logic [31:0] prev_pc;
        logic [31:0] rnd;
        logic [4:0]  rd;
        int          cycles;
        @(negedge clk);
        base = pc + 32'd8;  // Ahead of the fetch
        for (int i = 0; i < 8; i++) begin
            rnd = lcg_next();
            rd  = (i == 3) ? 5'd0 : rnd[8:4];  // One forced x0 write
            prog[base + 4 * i] = {rnd[31:12], rd, 7'b0110111};
            if (rd != 5'd0) begin
                imm         = {rnd[31:12], 12'h000};  // Upper immediate in place
                entry.valid = 1'b1;
                entry.rd    = rd;
                entry.data  = 64'($signed(imm));      // Widened with its sign
                expected.push_back(entry);
            end
        end
        prev_pc = pc;
        cycles  = 0;
        while (pc < base + 32'd48 && cycles < WAIT_MAX) begin
            @(negedge clk);
            cycles++;
            check_pc("pc", prev_pc + 32'd4, pc);  // Straight-line fetch
            prev_pc = pc;
            if (rf_write.valid && expected.size() == 0) begin
                errors++;
                $display("Unexpected register write to x%0d at %0t", rf_write.rd, $time);
            end else if (rf_write.valid) begin
                check_rf_write("rf_write", expected.pop_front(), rf_write);
            end
        end
        if (cycles >= WAIT_MAX) begin
            report_timeout("the end of the LUI sequence");
        end
        if (expected.size() != 0) begin
            errors++;
            $display("%0d register writes never appeared", expected.size());
        end
    endtask

    task automatic interrupt_round_trip();
        logic [7:0] codes [$];
        codes.push_back(random_code());
        prog.delete();
        prog[`HANDLER_PC]     = ECHO_WORD;
        prog[`HANDLER_PC + 4] = MRET_WORD;
        fork
            press_keys(codes);
            await_return();
        join
        collect_chars(codes);
    endtask

    task automatic order_under_backpressure();
        logic [7:0] codes [$];
        prog.delete();
        for (int i = 0; i < 3; i++) begin
            codes.push_back(random_code());
            prog[`HANDLER_PC + 4 * i] = ECHO_WORD;
        end
        prog[`HANDLER_PC + 12] = MRET_WORD;
        @(posedge clk);
        art_ready <= 1'b0;  // Sink stalls
        fork
            press_keys(codes);
            await_return();
        join
        if (seen_chars.size() != 0) begin
            errors++;
            $display("Characters left the queue while art_ready was low");
        end
        @(posedge clk);
        art_ready <= 1'b1;
        collect_chars(codes);
    endtask

    task automatic keyboard_overflow();
        logic [7:0] codes [$];
        logic [7:0] kept [$];
        prog.delete();
        for (int i = 0; i < 4; i++) begin
            prog[`HANDLER_PC + 4 * i] = NOP_WORD;  // Queue fills before any ECHO
        end
        for (int i = 0; i < `KBD_DEPTH; i++) begin
            prog[`HANDLER_PC + 16 + 4 * i] = ECHO_WORD;
        end
        prog[`HANDLER_PC + 16 + 4 * `KBD_DEPTH] = MRET_WORD;
        for (int i = 0; i < 5; i++) begin
            codes.push_back(random_code());
            if (i < `KBD_DEPTH) begin
                kept.push_back(codes[i]);
            end
        end
        fork
            press_keys(codes);
            await_return();
        join
        check_flag("kbd_overflow", 1'b1, kbd_overflow);
        collect_chars(kept);
    endtask

    initial begin
        reset       = 1'b0;
        instruction = NOP_WORD;
        key_valid   = 1'b0;
        key         = '0;
        art_ready   = 1'b1;
        lcg_state   = 67343;
        errors      = 0;
        timeouts    = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b1;
        reset_values();
        lui_trace();
        interrupt_round_trip();
        order_under_backpressure();
        keyboard_overflow();
        $display("Closing: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, u_echo_soc.u_echo_soc_properties.assert_fails);
        if (errors == 0 && timeouts == 0 && u_echo_soc.u_echo_soc_properties.assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/echo_pkg.sv
src/sync_fifo.sv
src/echo_core.sv
src/kbd_port.sv
src/art_port.sv
src/echo_soc.sv
dv/echo_soc_properties.sv
dv/echo_soc_tb.sv

/* Bender.yml */
package:
  name: echo_soc

sources:
  - include_dirs:
      - src
    files:
      - src/echo_pkg.sv
      - src/sync_fifo.sv
      - src/echo_core.sv
      - src/kbd_port.sv
      - src/art_port.sv
      - src/echo_soc.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/echo_soc_properties.sv
      - dv/echo_soc_tb.sv
